// ==== dv/memStage_sva.sv ====
module memStage_sva
  import memStagePkg::*;
(
  input logic      Clk,
  input logic      arstN,
  input logic      psel,
  input logic      penable,
  input logic      pready,
  input logic      pslverr,
  input logic      ramWriteEn,
  input logic      ramReadEn,
  input apbState_t state
);

  // pready only inside the access phase of a selected transfer
  readyInAccess: assert property (@(posedge Clk) disable iff (!arstN)
    pready |-> (psel && penable && state != apbIdle))
    else $error("pready raised outside the APB access phase");

  // A rejected access never reaches the RAM
  noWriteOnError: assert property (@(posedge Clk) disable iff (!arstN)
    !(ramWriteEn && pslverr))
    else $error("RAM write strobe together with pslverr");

  // One wait state on a read, then a clean response
  readReadyNext: assert property (@(posedge Clk) disable iff (!arstN)
    ramReadEn |=> (pready && !pslverr))
    else $error("read response did not follow the RAM read by one cycle");

endmodule

// Checker sits on the APB port next to the state register
bind apbMemPort memStage_sva sva_1 (
  .Clk        (Clk),
  .arstN      (arstN),
  .psel       (psel),
  .penable    (penable),
  .pready     (pready),
  .pslverr    (pslverr),
  .ramWriteEn (ramWriteEn),
  .ramReadEn  (ramReadEn),
  .state      (state)
);

// ==== dv/tbMemStage.sv ====
module tbMemStage
  import memStagePkg::*;
;

  localparam int addrWidth     = 12;
  localparam int memDepthWords = 512;
  localparam int idxBits       = $clog2(memDepthWords * bytesPerWord);
  localparam int readyTimeout  = 16;

  logic                 Clk;
  logic                 arstN;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [addrWidth-1:0] paddr;
  logic [dataWidth-1:0] pwdata;
  accessWidth_t         accessWidth;
  logic                 loadUnsigned;
  logic [dataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  // Reference byte memory in little endian lane order
  logic [7:0]           refMem [memDepthWords*bytesPerWord];

  // Expected response of the transfer in flight
  logic [dataWidth-1:0] expData;
  logic                 expErr;
  logic                 checkData;
  logic                 transferActive;

  logic [31:0]          rngState;
  logic [31:0]          r;
  logic [addrWidth-1:0] a;
  accessWidth_t         w;
  string                testName;
  int                   errorCount;
  int                   checkCount;
  int                   testErrors;
  int                   testsRun;
  int                   testsFailed;
  logic                 timedOut;

  memStageTop #(
    .addrWidth     (addrWidth),
    .memDepthWords (memDepthWords)
  ) dut (.*);

  always #2 Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Misaligned half or word, or word index past the end of memory
  function automatic logic accessIllegal(input logic [addrWidth-1:0] addr,
                                         input accessWidth_t width);
    logic misaligned;
    case (width)
      accWord: misaligned = (addr[1:0] != 2'b00);
      accHalf: misaligned = addr[0];
      default: misaligned = 1'b0;
    endcase
    return misaligned || (int'(addr[addrWidth-1:2]) >= memDepthWords);
  endfunction

  function automatic logic [dataWidth-1:0] refLoad(input logic [addrWidth-1:0] addr,
                                                   input accessWidth_t width,
                                                   input logic uns, output logic err);
    logic [idxBits-1:0]   idx;
    logic [dataWidth-1:0] result;
    idx    = addr[idxBits-1:0];
    err    = accessIllegal(addr, width);
    result = '0;
    if (!err) begin
      case (width)
        accWord: begin
          for (int k = 0; k < 4; k++) begin
            result[8*k +: 8] = refMem[idx + idxBits'(k)];
          end
        end
        accHalf: begin
          result[15:0] = {refMem[idx + idxBits'(1)], refMem[idx]};
          result = uns ? {16'h0, result[15:0]} : {{16{result[15]}}, result[15:0]};
        end
        default: begin
          result[7:0] = refMem[idx];
          result = uns ? {24'h0, result[7:0]} : {{24{result[7]}}, result[7:0]};
        end
      endcase
    end
    return result;
  endfunction

  // Called only for accepted writes
  task automatic refStore(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data,
                          input accessWidth_t width);
    logic [idxBits-1:0] idx;
    int                 count;
    idx   = addr[idxBits-1:0];
    count = (width == accWord) ? 4 : (width == accHalf) ? 2 : 1;
    for (int k = 0; k < count; k++) begin
      refMem[idx + idxBits'(k)] = data[8*k +: 8];
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Bus driver and response check
  //////////////////////////////////////////////////////////////////////////////

  task automatic apbTransfer(input logic wr, input logic [addrWidth-1:0] addr,
                             input logic [dataWidth-1:0] data, input accessWidth_t width,
                             input logic uns);
    logic                 err;
    logic [dataWidth-1:0] loadVal;
    int                   waitCount;
    int                   expWaits;
    if (!timedOut) begin
      loadVal  = refLoad(addr, width, uns, err);
      // Writes and errors finish at once, a legal read has one wait state
      expWaits = (wr || err) ? 0 : 1;
      // Setup phase
      @(negedge Clk);
      psel           = 1'b1;
      penable        = 1'b0;
      pwrite         = wr;
      paddr          = addr;
      pwdata         = data;
      accessWidth    = width;
      loadUnsigned   = uns;
      expErr         = err;
      expData        = loadVal;
      checkData      = err || !wr;
      transferActive = 1'b1;
      // Access phase, held until pready
      @(negedge Clk);
      penable   = 1'b1;
      waitCount = 0;
      @(posedge Clk);
      while (!pready && waitCount < readyTimeout) begin
        waitCount++;
        @(posedge Clk);
      end
      if (!pready) begin
        $display("Timeout in test %s, pready stayed low for %0d cycles", testName, readyTimeout);
        errorCount++;
        timedOut = 1'b1;
      end else begin
        checkCount++;
        assert (waitCount == expWaits) else begin
          $display("[ERROR] %s addr %03h wait states expected %0d actual %0d",
                   testName, addr, expWaits, waitCount);
          errorCount++;
        end
        if (wr && !err) begin
          refStore(addr, data, width);
        end
      end
      @(negedge Clk);
      psel           = 1'b0;
      penable        = 1'b0;
      transferActive = 1'b0;
    end
  endtask

  // Response sampled at the rising edge with inputs settled since the falling edge
  always @(posedge Clk) begin
    if (arstN && pready) begin
      checkCount++;
      assert (transferActive) else begin
        $display("pready high with no transfer in flight in test %s", testName);
        errorCount++;
      end
      assert (pslverr === expErr) else begin
        $display("[ERROR] %s addr %03h pslverr expected %0b actual %0b",
                 testName, paddr, expErr, pslverr);
        errorCount++;
      end
      if (checkData) begin
        assert (prdata === expData) else begin
          $display("[ERROR] %s addr %03h prdata expected %08h actual %08h",
                   testName, paddr, expData, prdata);
          errorCount++;
        end
      end
    end
  end

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = errorCount;
  endtask

  task automatic endTest();
    testsRun++;
    if (errorCount == testErrors) begin
      $display("test %s: passed", testName);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", testName, errorCount - testErrors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    Clk            = 1'b0;
    arstN          = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    accessWidth    = accWord;
    loadUnsigned   = 1'b0;
    expData        = '0;
    expErr         = 1'b0;
    checkData      = 1'b0;
    transferActive = 1'b0;
    rngState       = 32'hea38_5305;
    errorCount     = 0;
    checkCount     = 0;
    testErrors     = 0;
    testsRun       = 0;
    testsFailed    = 0;
    timedOut       = 1'b0;
    testName       = "reset";
    repeat (5) @(posedge Clk);
    @(negedge Clk);
    arstN = 1'b1;

    // Bus idle, slave must stay quiet
    beginTest("reset");
    repeat (4) begin
      @(posedge Clk);
      checkCount++;
      assert (!pready && !pslverr) else begin
        $display("[ERROR] %s pready/pslverr expected 00 actual %0b%0b", testName, pready, pslverr);
        errorCount++;
      end
    end
    endTest();

    // Every word gets a value from its own address
    beginTest("fill");
    for (int i = 0; i < memDepthWords; i++) begin
      apbTransfer(1'b1, addrWidth'(i * 4), 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f, accWord, 1'b0);
    end
    endTest();

    beginTest("word round trip");
    for (int k = 0; k < 3; k++) begin
      a = (k == 0) ? 12'h000 : (k == 1) ? 12'h7fc : 12'h404;
      rngState = xorshift32(rngState);
      apbTransfer(1'b1, a, rngState, accWord, 1'b0);
      apbTransfer(1'b0, a, '0, accWord, 1'b0);
    end
    endTest();

    // Byte and half stores merged into one word
    beginTest("lane isolation");
    apbTransfer(1'b1, 12'h200, 32'h1122_3344, accWord, 1'b0);
    apbTransfer(1'b1, 12'h201, 32'h0000_00ab, accByte, 1'b0);
    apbTransfer(1'b1, 12'h202, 32'h0000_cdef, accHalf, 1'b0);
    apbTransfer(1'b0, 12'h200, '0, accWord, 1'b0);
    apbTransfer(1'b1, 12'h210, 32'hffff_5566, accHalf, 1'b0);
    apbTransfer(1'b1, 12'h213, 32'hffff_ff99, accByte, 1'b0);
    apbTransfer(1'b0, 12'h210, '0, accWord, 1'b0);
    endTest();

    // Top bits set in byte 0 and the upper half only
    beginTest("extension");
    apbTransfer(1'b1, 12'h180, 32'h80f0_7f81, accWord, 1'b0);
    for (int u = 0; u < 2; u++) begin
      apbTransfer(1'b0, 12'h180, '0, accByte, u[0]);
      apbTransfer(1'b0, 12'h181, '0, accByte, u[0]);
      apbTransfer(1'b0, 12'h180, '0, accHalf, u[0]);
      apbTransfer(1'b0, 12'h182, '0, accHalf, u[0]);
    end
    endTest();

    // 0x800 and 0xa01 alias words 0 and 0x80 in the low index bits
    beginTest("rejected accesses");
    apbTransfer(1'b1, 12'h301, 32'hdead_beef, accHalf, 1'b0);
    apbTransfer(1'b1, 12'h302, 32'hdead_beef, accWord, 1'b0);
    apbTransfer(1'b1, 12'h800, 32'hdead_beef, accWord, 1'b0);
    apbTransfer(1'b1, 12'ha01, 32'hdead_beef, accByte, 1'b0);
    apbTransfer(1'b0, 12'h303, '0, accHalf, 1'b0);
    apbTransfer(1'b0, 12'hffc, '0, accWord, 1'b0);
    apbTransfer(1'b0, 12'h300, '0, accWord, 1'b0);
    apbTransfer(1'b0, 12'h000, '0, accWord, 1'b0);
    apbTransfer(1'b0, 12'h200, '0, accWord, 1'b0);
    endTest();

    // Mostly aligned accesses with about one in eight out of range
    beginTest("random mix");
    for (int n = 0; n < 300; n++) begin
      rngState = xorshift32(rngState);
      r = rngState;
      w = (r[1:0] == 2'd0) ? accWord : (r[1:0] == 2'd1) ? accHalf : accByte;
      a = {(r[7:5] == 3'b000), r[18:8]};
      if (r[4:3] != 2'b00) begin
        if (w == accWord) a[1:0] = 2'b00;
        else if (w == accHalf) a[0] = 1'b0;
      end
      rngState = xorshift32(rngState);
      apbTransfer(r[2], a, rngState, w, r[19]);
    end
    endTest();

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checkCount, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module tbMemStage \
  -Mdir "$buildDir" -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/VtbMemStage" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1

// ==== sources.f ====
verilog/memStagePkg.sv
verilog/storeAligner.sv
verilog/byteLaneRam.sv
verilog/loadExtractor.sv
verilog/apbMemPort.sv
verilog/memStageTop.sv
dv/memStage_sva.sv
dv/tbMemStage.sv

// ==== verilog/apbMemPort.sv ====
module apbMemPort
  import memStagePkg::*;
#(
  parameter int addrWidth     = 12,
  parameter int memDepthWords = 512
) (
  input  logic                             Clk,
  input  logic                             arstN,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [addrWidth-1:0]             paddr,
  input  accessWidth_t                     accessWidth,
  output logic                             pready,
  output logic                             pslverr,
  output logic                             ramWriteEn,
  output logic                             ramReadEn,
  output logic [$clog2(memDepthWords)-1:0] wordIndex
);

  // Index bits into the RAM and bits of the full word address on the bus
  localparam int idxWidth      = $clog2(memDepthWords);
  localparam int wordAddrWidth = addrWidth - laneBits;

  apbState_t state;
  apbState_t nextState;

  logic [wordAddrWidth-1:0] wordAddr;
  logic [31:0]              wordAddrExt;
  logic                     misaligned;
  logic                     outOfRange;
  logic                     illegal;
  logic                     accessCycle;
  logic                     readLaunch;

  ////////////////////////////////////////////////////////////////////////////
  // Address checks
  ////////////////////////////////////////////////////////////////////////////

  // Word part of the byte address, lane bits dropped
  assign wordAddr    = paddr[addrWidth-1:laneBits];
  assign wordAddrExt = 32'(wordAddr);

  // Half needs bit 0 clear, word needs both lane bits clear
  always_comb begin
    case (accessWidth)
      accWord: misaligned = |paddr[laneBits-1:0];
      accHalf: misaligned = paddr[0];
      accByte: misaligned = 1'b0;
      // Unused width code is refused as well
      default: misaligned = 1'b1;
    endcase
  end

  // Anything past the last word gets an error response
  assign outOfRange = (wordAddrExt >= memDepthWords);
  assign illegal    = misaligned | outOfRange;

  // Low index bits go to the RAM, the range check covers the rest
  assign wordIndex = wordAddr[idxWidth-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  // First access cycle, qualified with the bus strobes
  assign accessCycle = (state == apbAccess) && psel && penable;

  // Legal read, result comes back next cycle
  assign readLaunch = accessCycle && !pwrite && !illegal;

  always_comb begin
    nextState = state;
    case (state)
      apbIdle: begin
        // Setup phase seen, access phase follows
        if (psel && !penable) begin
          nextState = apbAccess;
        end
      end
      apbAccess: begin
        // Writes and errors finish here, reads take one more cycle
        nextState = readLaunch ? apbRespond : apbIdle;
      end
      apbRespond: begin
        nextState = apbIdle;
      end
      default: begin
        nextState = apbIdle;
      end
    endcase
  end

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      state <= apbIdle;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus response and RAM strobes
  ////////////////////////////////////////////////////////////////////////////

  // Zero wait states for write and error, one for read
  assign pready  = (accessCycle && (pwrite || illegal)) || (state == apbRespond);
  assign pslverr = accessCycle && illegal;

  // RAM only sees legal accesses
  assign ramWriteEn = accessCycle && pwrite && !illegal;
  assign ramReadEn  = readLaunch;

endmodule

// ==== verilog/byteLaneRam.sv ====
module byteLaneRam
  import memStagePkg::*;
#(
  parameter int memDepthWords = 512
) (
  input  logic                             Clk,
  input  logic [$clog2(memDepthWords)-1:0] wordIndex,
  input  logic                             ramWriteEn,
  input  logic                             ramReadEn,
  input  logic [dataWidth-1:0]             laneData,
  input  logic [bytesPerWord-1:0]          byteEnable,
  output logic [dataWidth-1:0]             ramReadWord
);

  // Word storage, one entry per word address
  logic [dataWidth-1:0] mem [memDepthWords];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Only enabled lanes change, the rest of the word keeps its value
  always_ff @(posedge Clk) begin
    if (ramWriteEn) begin
      for (int lane = 0; lane < bytesPerWord; lane++) begin
        if (byteEnable[lane]) begin
          mem[wordIndex][lane*byteWidth +: byteWidth] <=
            laneData[lane*byteWidth +: byteWidth];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Whole word registered, lane pick happens downstream
  // Holds its value between reads
  always_ff @(posedge Clk) begin
    if (ramReadEn) begin
      ramReadWord <= mem[wordIndex];
    end
  end

endmodule

// ==== verilog/loadExtractor.sv ====
module loadExtractor
  import memStagePkg::*;
(
  input  logic [dataWidth-1:0] ramReadWord,
  input  logic [laneBits-1:0]  laneOffset,
  input  accessWidth_t         accessWidth,
  input  logic                 loadUnsigned,
  input  logic                 pslverr,
  output logic [dataWidth-1:0] loadData
);

  logic [dataWidth-1:0]   halfShifted;
  logic [dataWidth-1:0]   byteShifted;
  logic [2*byteWidth-1:0] pickedHalf;
  logic [byteWidth-1:0]   pickedByte;
  logic [dataWidth-1:0]   halfExt;
  logic [dataWidth-1:0]   byteExt;

  ////////////////////////////////////////////////////////////////////////////
  // Lane select
  ////////////////////////////////////////////////////////////////////////////

  // Addressed half or byte shifted down to bit 0
  assign halfShifted = ramReadWord >> (2 * byteWidth * laneOffset[laneBits-1]);
  assign byteShifted = ramReadWord >> (byteWidth * laneOffset);

  assign pickedHalf = halfShifted[2*byteWidth-1:0];
  assign pickedByte = byteShifted[byteWidth-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////////////////////

  // LHU / LBU fill with zeros, LH / LB copy the top bit
  assign halfExt = loadUnsigned ? dataWidth'(pickedHalf)
                                : {{(dataWidth-2*byteWidth){pickedHalf[2*byteWidth-1]}},
                                   pickedHalf};
  assign byteExt = loadUnsigned ? dataWidth'(pickedByte)
                                : {{(dataWidth-byteWidth){pickedByte[byteWidth-1]}},
                                   pickedByte};

  always_comb begin
    if (pslverr) begin
      // Rejected access returns zero data
      loadData = '0;
    end else begin
      case (accessWidth)
        accWord: loadData = ramReadWord;
        accHalf: loadData = halfExt;
        accByte: loadData = byteExt;
        default: loadData = '0;
      endcase
    end
  end

endmodule

// ==== verilog/memStagePkg.sv ====
package memStagePkg;

  //////////////////////////////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////////////////////////////

  // Width of one data word on the bus and in the RAM
  parameter int dataWidth = 32;

  // Byte lanes per word
  parameter int bytesPerWord = 4;

  // Bits of one byte lane
  parameter int byteWidth = dataWidth / bytesPerWord;

  // Address bits that pick the lane inside a word
  parameter int laneBits = $clog2(bytesPerWord);

  //////////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////////

  // Size of a load or store, same coding as the old pipeline controller
  typedef enum logic [1:0] {
    accWord = 2'b00,
    accHalf = 2'b01,
    accByte = 2'b10
  } accessWidth_t;

  // APB slave states
  // Idle covers the setup cycle too
  // Respond is the extra cycle of a read
  typedef enum logic [1:0] {
    apbIdle    = 2'b00,
    apbAccess  = 2'b01,
    apbRespond = 2'b10
  } apbState_t;

endpackage

// ==== verilog/memStageTop.sv ====
module memStageTop
  import memStagePkg::*;
#(
  parameter int addrWidth     = 12,
  parameter int memDepthWords = 512
) (
  input  logic                 Clk,
  input  logic                 arstN,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [addrWidth-1:0] paddr,
  input  logic [dataWidth-1:0] pwdata,
  input  accessWidth_t         accessWidth,
  input  logic                 loadUnsigned,
  output logic [dataWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr
);

  localparam int idxWidth = $clog2(memDepthWords);

  // Port to RAM control
  logic                    ramWriteEn;
  logic                    ramReadEn;
  logic [idxWidth-1:0]     wordIndex;

  // Store path
  logic [dataWidth-1:0]    laneData;
  logic [bytesPerWord-1:0] byteEnable;

  // Load path
  logic [dataWidth-1:0]    ramReadWord;

  ////////////////////////////////////////////////////////////////////////////
  // APB handshake, checks and RAM strobes
  ////////////////////////////////////////////////////////////////////////////

  apbMemPort #(
    .addrWidth     (addrWidth),
    .memDepthWords (memDepthWords)
  ) apbMemPort_1 (
    .Clk         (Clk),
    .arstN       (arstN),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .accessWidth (accessWidth),
    .pready      (pready),
    .pslverr     (pslverr),
    .ramWriteEn  (ramWriteEn),
    .ramReadEn   (ramReadEn),
    .wordIndex   (wordIndex)
  );

  // Store data into its lanes
  storeAligner storeAligner_1 (
    .pwdata      (pwdata),
    .laneOffset  (paddr[laneBits-1:0]),
    .accessWidth (accessWidth),
    .laneData    (laneData),
    .byteEnable  (byteEnable)
  );

  byteLaneRam #(
    .memDepthWords (memDepthWords)
  ) byteLaneRam_1 (
    .Clk         (Clk),
    .wordIndex   (wordIndex),
    .ramWriteEn  (ramWriteEn),
    .ramReadEn   (ramReadEn),
    .laneData    (laneData),
    .byteEnable  (byteEnable),
    .ramReadWord (ramReadWord)
  );

  // Lane pick and extension, paddr is still held in the respond cycle
  loadExtractor loadExtractor_1 (
    .ramReadWord  (ramReadWord),
    .laneOffset   (paddr[laneBits-1:0]),
    .accessWidth  (accessWidth),
    .loadUnsigned (loadUnsigned),
    .pslverr      (pslverr),
    .loadData     (prdata)
  );

endmodule

// ==== verilog/storeAligner.sv ====
module storeAligner
  import memStagePkg::*;
(
  input  logic [dataWidth-1:0]    pwdata,
  input  logic [laneBits-1:0]     laneOffset,
  input  accessWidth_t            accessWidth,
  output logic [dataWidth-1:0]    laneData,
  output logic [bytesPerWord-1:0] byteEnable
);

  // Half select is the upper lane bit
  logic                     halfSel;
  logic [dataWidth-1:0]     halfData;
  logic [dataWidth-1:0]     byteData;
  logic [bytesPerWord-1:0]  halfEnable;
  logic [bytesPerWord-1:0]  byteEn;

  assign halfSel = laneOffset[laneBits-1];

  ////////////////////////////////////////////////////////////////////////////
  // Lane placement
  ////////////////////////////////////////////////////////////////////////////

  // Low half of the store data moved into the upper or lower half word
  assign halfData   = dataWidth'(pwdata[2*byteWidth-1:0]) << (2 * byteWidth * halfSel);
  assign halfEnable = bytesPerWord'(2'b11) << (2 * halfSel);

  // Low byte moved into the addressed lane
  assign byteData = dataWidth'(pwdata[byteWidth-1:0]) << (byteWidth * laneOffset);
  assign byteEn   = bytesPerWord'(1'b1) << laneOffset;

  ////////////////////////////////////////////////////////////////////////////
  // Width select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Nothing written for an unknown width
    laneData   = '0;
    byteEnable = '0;
    case (accessWidth)
      accWord: begin
        laneData   = pwdata;
        byteEnable = '1;
      end
      accHalf: begin
        laneData   = halfData;
        byteEnable = halfEnable;
      end
      accByte: begin
        laneData   = byteData;
        byteEnable = byteEn;
      end
      default: begin
        laneData   = '0;
        byteEnable = '0;
      end
    endcase
  end

endmodule
